// File: logic/mul_macros.svh
/* outer product widths and address map */
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// q13 fixed point in a 26 bit word
`define MUL_DATA_W 26
`define MUL_FRAC_W 13

// gates, and elements per vector
`define MUL_N 4

// apb side
`define MUL_ADDR_W 12
`define MUL_WORD_W 32

// byte addresses
`define MUL_ADDR_W_BASE     12'h000
`define MUL_ADDR_Z_BASE     12'h040
`define MUL_ADDR_CTRL       12'h050
`define MUL_ADDR_START      12'h054
`define MUL_ADDR_STATUS     12'h058
`define MUL_ADDR_ZSNAP_BASE 12'h060
`define MUL_ADDR_RES_BASE   12'h100

`endif

// File: logic/fixed_pkg.sv
/* fixed-point types */
`include "mul_macros.svh"

package fixed_pkg;

    typedef logic signed [`MUL_DATA_W-1:0] data_t;
    // full product before the q13 slice
    typedef logic signed [2*`MUL_DATA_W-1:0] prod_t;
    typedef logic [$clog2(`MUL_N)-1:0] idx_t;
    typedef logic [$clog2(`MUL_N*`MUL_N*`MUL_N)-1:0] res_idx_t;

    typedef struct packed {
        data_t e0;
        data_t e1;
        data_t e2;
        data_t e3;
    } vec_t;

    typedef struct packed {
        vec_t g0;
        vec_t g1;
        vec_t g2;
        vec_t g3;
    } wset_t;

    typedef struct packed {
        logic  mode;
        vec_t  z;
        wset_t w;
    } operand_t;

    // elem index is 16k+4i+j
    typedef struct packed {
        data_t [`MUL_N*`MUL_N*`MUL_N-1:0] elem;
        vec_t                             zsnap;
    } result_t;

    function automatic data_t vec_el(vec_t v, idx_t n);
        case (n)
            2'd0:    return v.e0;
            2'd1:    return v.e1;
            2'd2:    return v.e2;
            default: return v.e3;
        endcase
    endfunction

    // sign extend to a bus word
    function automatic logic [`MUL_WORD_W-1:0] to_word(data_t d);
        return {{(`MUL_WORD_W-`MUL_DATA_W){d[`MUL_DATA_W-1]}}, d};
    endfunction

endpackage

// File: logic/apb_pkg.sv
/* apb bus types */
`include "mul_macros.svh"

package apb_pkg;

    typedef logic [`MUL_ADDR_W-1:0] addr_t;
    typedef logic [`MUL_WORD_W-1:0] word_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    // pready stays high, no wait states
    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// File: logic/weight_regfile.sv
/* operand register file */
`include "mul_macros.svh"

module weight_regfile (
    input  logic                clk_mul,
    input  logic                rst_n,
    input  apb_pkg::apb_req_t   req,
    input  logic                sel,
    output apb_pkg::apb_rsp_t   rsp,
    output fixed_pkg::operand_t operand,
    output logic                start
);

    // byte span of one vector, and of the whole weight set
    localparam int VEC_BITS = $bits(fixed_pkg::idx_t) + 2;
    localparam int SET_BITS = VEC_BITS + $bits(fixed_pkg::idx_t);

    fixed_pkg::data_t [0:`MUL_N-1][0:`MUL_N-1] w_q;
    fixed_pkg::data_t [0:`MUL_N-1]             z_q;
    logic                                      mode_q;

    logic             access;
    logic             wr;
    apb_pkg::addr_t   word_addr;
    apb_pkg::addr_t   w_off;
    apb_pkg::addr_t   z_off;
    apb_pkg::addr_t   zsnap_off;
    logic             is_w;
    logic             is_z;
    logic             is_ctrl;
    logic             is_start;
    logic             is_status;
    logic             is_zsnap;
    logic             unmapped;
    fixed_pkg::idx_t  gate_k;
    fixed_pkg::idx_t  elem_i;
    fixed_pkg::idx_t  elem_j;
    fixed_pkg::data_t wdata;

    assign access = sel && req.psel && req.penable;
    assign wr     = access && req.pwrite;
    assign wdata  = req.pwdata[`MUL_DATA_W-1:0];

    assign word_addr = {req.paddr[`MUL_ADDR_W-1:2], 2'b00};
    assign w_off     = word_addr - `MUL_ADDR_W_BASE;
    assign z_off     = word_addr - `MUL_ADDR_Z_BASE;
    assign zsnap_off = word_addr - `MUL_ADDR_ZSNAP_BASE;

    assign is_w      = (w_off[`MUL_ADDR_W-1:SET_BITS] == '0);
    assign is_z      = (z_off[`MUL_ADDR_W-1:VEC_BITS] == '0);
    assign is_ctrl   = (word_addr == `MUL_ADDR_CTRL);
    assign is_start  = (word_addr == `MUL_ADDR_START);
    assign is_status = (word_addr == `MUL_ADDR_STATUS);
    assign is_zsnap  = (zsnap_off[`MUL_ADDR_W-1:VEC_BITS] == '0);
    assign unmapped  = !(is_w || is_z || is_ctrl || is_start || is_status || is_zsnap);

    assign gate_k = w_off[SET_BITS-1:VEC_BITS];
    assign elem_i = w_off[VEC_BITS-1:2];
    assign elem_j = z_off[VEC_BITS-1:2];

    // e0 is the msb field, the same as index 0
    assign operand = '{
        mode: mode_q,
        z:    fixed_pkg::vec_t'(z_q),
        w:    fixed_pkg::wset_t'(w_q)
    };

    always_ff @(posedge clk_mul or negedge rst_n) begin
        if (!rst_n) begin
            w_q    <= '0;
            z_q    <= '0;
            mode_q <= 1'b0;
            start  <= 1'b0;
        end else begin
            // one cycle pulse after the start write
            start <= wr && is_start;
            if (wr && is_w) begin
                w_q[gate_k][elem_i] <= wdata;
            end
            if (wr && is_z) begin
                z_q[elem_j] <= wdata;
            end
            if (wr && is_ctrl) begin
                mode_q <= req.pwdata[0];
            end
        end
    end

    always_comb begin
        rsp.prdata  = '0;
        rsp.pready  = 1'b1;
        rsp.pslverr = 1'b0;
        if (access) begin
            if (!req.pwrite) begin
                if (is_w) begin
                    rsp.prdata = fixed_pkg::to_word(w_q[gate_k][elem_i]);
                end else if (is_z) begin
                    rsp.prdata = fixed_pkg::to_word(z_q[elem_j]);
                end else if (is_ctrl) begin
                    rsp.prdata = {{(`MUL_WORD_W-1){1'b0}}, mode_q};
                end
            end
            // status and zsnap data are filled in by the top level
            rsp.pslverr = unmapped || (req.pwrite && (is_status || is_zsnap));
        end
    end

endmodule

// File: logic/outer_product_array.sv
/* gate outer product array */
`include "mul_macros.svh"

module outer_product_array (
    input  logic                clk_mul,
    input  logic                rst_n,
    input  fixed_pkg::operand_t operand,
    input  logic                start,
    output fixed_pkg::result_t  result,
    output logic                result_valid
);

    fixed_pkg::data_t [0:`MUL_N-1]             z_v;
    fixed_pkg::data_t [0:`MUL_N-1][0:`MUL_N-1] w_v;
    fixed_pkg::result_t                        next_result;

    // index 0 lines up with e0 and g0
    assign z_v = operand.z;
    assign w_v = operand.w;

    always_comb begin
        fixed_pkg::prod_t prod;
        prod = '0;
        next_result.elem  = '0;
        next_result.zsnap = operand.z;
        for (int k = 0; k < `MUL_N; k++) begin
            for (int i = 0; i < `MUL_N; i++) begin
                for (int j = 0; j < `MUL_N; j++) begin
                    prod = fixed_pkg::prod_t'(z_v[j]) * fixed_pkg::prod_t'(w_v[k][i]);
                    if (operand.mode) begin
                        // truncate back to q13, high bits wrap
                        next_result.elem[`MUL_N*`MUL_N*k + `MUL_N*i + j] =
                            prod[`MUL_FRAC_W+`MUL_DATA_W-1:`MUL_FRAC_W];
                    end else begin
                        // bypass repeats the weight row for every i
                        next_result.elem[`MUL_N*`MUL_N*k + `MUL_N*i + j] = w_v[k][j];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_mul or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= start;
            if (start) begin
                result <= next_result;
            end
        end
    end

endmodule

// File: logic/product_readout.sv
/* result store and readout */
`include "mul_macros.svh"

module product_readout (
    input  logic               clk_mul,
    input  logic               rst_n,
    input  fixed_pkg::result_t result,
    input  logic               result_valid,
    input  logic               start,
    input  apb_pkg::apb_req_t  req,
    input  logic               sel,
    output apb_pkg::apb_rsp_t  rsp,
    output logic               done,
    output fixed_pkg::vec_t    zsnap
);

    // byte span of the result window
    localparam int RES_BITS = $bits(fixed_pkg::res_idx_t) + 2;

    fixed_pkg::result_t    res_q;
    logic                  access;
    logic                  start_wr;
    apb_pkg::addr_t        word_addr;
    apb_pkg::addr_t        res_off;
    logic                  idx_ok;
    fixed_pkg::res_idx_t   idx;

    assign access    = sel && req.psel && req.penable;
    assign word_addr = {req.paddr[`MUL_ADDR_W-1:2], 2'b00};

    // start write on the bus, in the regfile range
    assign start_wr = req.psel && req.penable && req.pwrite &&
                      (word_addr == `MUL_ADDR_START);

    assign res_off = word_addr - `MUL_ADDR_RES_BASE;
    assign idx_ok  = (res_off[`MUL_ADDR_W-1:RES_BITS] == '0);
    assign idx     = res_off[RES_BITS-1:2];

    always_ff @(posedge clk_mul or negedge rst_n) begin
        if (!rst_n) begin
            res_q <= '0;
            done  <= 1'b0;
        end else begin
            if (result_valid) begin
                res_q <= result;
            end
            // a new start wins over a capture in the same cycle
            if (start_wr || start) begin
                done <= 1'b0;
            end else if (result_valid) begin
                done <= 1'b1;
            end
        end
    end

    assign zsnap = res_q.zsnap;

    always_comb begin
        rsp.prdata  = '0;
        rsp.pready  = 1'b1;
        rsp.pslverr = 1'b0;
        if (access) begin
            if (!req.pwrite && idx_ok) begin
                rsp.prdata = fixed_pkg::to_word(res_q.elem[idx]);
            end
            // results are read only
            rsp.pslverr = req.pwrite || !idx_ok;
        end
    end

endmodule

// File: logic/outer_product_top.sv
/* outer product engine top */
`include "mul_macros.svh"

module outer_product_top (
    input  logic              clk_mul,
    input  logic              rst_n,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);

    localparam int VEC_BITS = $bits(fixed_pkg::idx_t) + 2;

    apb_pkg::apb_rsp_t   rsp_reg;
    apb_pkg::apb_rsp_t   rsp_res;
    fixed_pkg::operand_t operand;
    fixed_pkg::result_t  result;
    fixed_pkg::vec_t     zsnap;
    logic                start;
    logic                result_valid;
    logic                done;
    logic                sel_res;
    logic                rd_low;
    apb_pkg::addr_t      word_addr;
    apb_pkg::addr_t      zsnap_off;

    // bit 8 splits results from registers
    assign sel_res   = req.paddr[8];
    assign rd_low    = !sel_res && req.psel && req.penable && !req.pwrite;
    assign word_addr = {req.paddr[`MUL_ADDR_W-1:2], 2'b00};
    assign zsnap_off = word_addr - `MUL_ADDR_ZSNAP_BASE;

    weight_regfile u_regfile (
        .clk_mul (clk_mul),
        .rst_n   (rst_n),
        .req     (req),
        .sel     (!sel_res),
        .rsp     (rsp_reg),
        .operand (operand),
        .start   (start)
    );

    outer_product_array u_array (
        .clk_mul      (clk_mul),
        .rst_n        (rst_n),
        .operand      (operand),
        .start        (start),
        .result       (result),
        .result_valid (result_valid)
    );

    product_readout u_readout (
        .clk_mul      (clk_mul),
        .rst_n        (rst_n),
        .result       (result),
        .result_valid (result_valid),
        .start        (start),
        .req          (req),
        .sel          (sel_res),
        .rsp          (rsp_res),
        .done         (done),
        .zsnap        (zsnap)
    );

    always_comb begin
        rsp = sel_res ? rsp_res : rsp_reg;
        // status and snapshot live in the readout
        if (rd_low) begin
            if (word_addr == `MUL_ADDR_STATUS) begin
                rsp.prdata = {{(`MUL_WORD_W-1){1'b0}}, done};
            end else if (zsnap_off[`MUL_ADDR_W-1:VEC_BITS] == '0) begin
                rsp.prdata = fixed_pkg::to_word(
                    fixed_pkg::vec_el(zsnap, zsnap_off[VEC_BITS-1:2]));
            end
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
/* testbench clock and reset */
module tb_clock_gen (
    output logic clk_mul,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk_mul = 1'b0;
        forever #10 clk_mul = ~clk_mul;
    end

    // held low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_mul);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: verification/outer_product_tb.sv
/* outer product engine testbench */
`include "mul_macros.svh"

module outer_product_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES   = 10;
    localparam int CASE_CYCLES = 200;
    localparam int RB_CASE     = 2;
    localparam int MAX_POLLS   = 10;

    typedef logic [`MUL_DATA_W-1:0] val_t;
    typedef struct packed {
        logic                                           mode;
        logic [`MUL_N-1:0][`MUL_DATA_W-1:0]             z;
        logic [`MUL_N-1:0][`MUL_N-1:0][`MUL_DATA_W-1:0] w;
    } test_case_t;

    logic              clk_mul;
    logic              rst_n;
    apb_pkg::apb_req_t req;
    apb_pkg::apb_rsp_t rsp;
    test_case_t        cases [NUM_CASES];
    integer            seed;
    int                errors;

    tb_clock_gen clock_gen (.clk_mul(clk_mul), .rst_n(rst_n));
    outer_product_top UUT (.clk_mul(clk_mul), .rst_n(rst_n), .req(req), .rsp(rsp));

    function automatic logic [31:0] sext(val_t v);
        return {{(32-`MUL_DATA_W){v[`MUL_DATA_W-1]}}, v};
    endfunction

    // q13 product, high bits wrap
    function automatic logic [31:0] q13_mul(val_t a, val_t b);
        longint p;
        p = longint'(signed'(a)) * longint'(signed'(b));
        return sext(p[`MUL_FRAC_W+`MUL_DATA_W-1:`MUL_FRAC_W]);
    endfunction

    function automatic logic [31:0] expected(test_case_t t, int k, int i, int j);
        if (t.mode) begin
            return q13_mul(t.z[j], t.w[k][i]);
        end else begin
            return sext(t.w[k][j]);
        end
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            errors++;
            $display("mismatch %s exp %h got %h", name, exp, got);
            $display("Errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // setup then access, sampled in the middle of the access phase
    task automatic transfer(logic wr, logic [11:0] addr, logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk_mul);
        #2;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk_mul);
        #2;
        req.penable = 1'b1;
        @(negedge clk_mul);
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        // no wait states, so pready is high in every access phase
        check_value("pready", 32'h1, {31'b0, rsp.pready});
    endtask

    task automatic bus_idle();
        @(posedge clk_mul);
        #2;
        req = '0;
    endtask

    task automatic write_word(logic [11:0] addr, logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        transfer(1'b1, addr, data, rd, err);
        check_value($sformatf("pslverr_wr_%h", addr), 32'h0, {31'b0, err});
    endtask

    task automatic read_check(string name, logic [11:0] addr, logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        transfer(1'b0, addr, 32'h0, rd, err);
        check_value(name, exp, rd);
        check_value($sformatf("%s_pslverr", name), 32'h0, {31'b0, err});
    endtask

    task automatic expect_error(string name, logic wr, logic [11:0] addr);
        logic [31:0] rd;
        logic        err;
        transfer(wr, addr, 32'h0155_5555, rd, err);
        check_value(name, 32'h1, {31'b0, err});
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        rd    = '0;
        while (rd[0] !== 1'b1) begin
            if (polls == MAX_POLLS) begin
                errors++;
                $display("done flag did not rise within %0d status reads", MAX_POLLS);
                $display("Errors found");
                $fatal(1, "no done after start");
            end
            transfer(1'b0, `MUL_ADDR_STATUS, 32'h0, rd, err);
            polls++;
        end
    endtask

    // cases 0..3 are corner values, the rest random
    task automatic build_table();
        val_t corners [4];
        corners = '{26'h1FFFFFF, 26'h2000000, 26'h0002000, 26'h3FFFFFF};
        cases[0].z = '0;
        cases[1].z = {26'h3FFE800, 26'h0001000, 26'h3FFE000, 26'h0002000};
        cases[2].z = {26'h3FFFFFF, 26'h0002000, 26'h2000000, 26'h1FFFFFF};
        cases[3].z = {26'h0000123, 26'h3FFFF00, 26'h0002000, 26'h0000000};
        for (int c = 0; c < NUM_CASES; c++) begin
            cases[c].mode = (c < 3) || (c > 3 && c[0]);
            for (int n = 0; n < `MUL_N; n++) begin
                if (c > 3) begin
                    cases[c].z[n] = 26'($random(seed));
                end
            end
            for (int k = 0; k < `MUL_N; k++) begin
                for (int i = 0; i < `MUL_N; i++) begin
                    case (c)
                        0:       cases[c].w[k][i] = '0;
                        1:       cases[c].w[k][i] = 26'((4*k + i - 7) * 1024);
                        2:       cases[c].w[k][i] = corners[(k + i) % 4];
                        3:       cases[c].w[k][i] = 26'((i[0] ? -1 : 1) * (16*k + i + 1) * 273);
                        default: cases[c].w[k][i] = 26'($random(seed));
                    endcase
                end
            end
        end
    endtask

    task automatic run_case(int c);
        test_case_t t;
        t = cases[c];
        for (int k = 0; k < `MUL_N; k++) begin
            for (int i = 0; i < `MUL_N; i++) begin
                write_word(12'(`MUL_ADDR_W_BASE + 16*k + 4*i), sext(t.w[k][i]));
            end
        end
        for (int j = 0; j < `MUL_N; j++) begin
            write_word(12'(`MUL_ADDR_Z_BASE + 4*j), sext(t.z[j]));
        end
        write_word(`MUL_ADDR_CTRL, {31'b0, t.mode});
        if (c == RB_CASE) begin
            for (int k = 0; k < `MUL_N; k++) begin
                for (int i = 0; i < `MUL_N; i++) begin
                    read_check($sformatf("w_%0d_%0d", k, i),
                               12'(`MUL_ADDR_W_BASE + 16*k + 4*i), sext(t.w[k][i]));
                end
            end
            for (int j = 0; j < `MUL_N; j++) begin
                read_check($sformatf("z_%0d", j), 12'(`MUL_ADDR_Z_BASE + 4*j), sext(t.z[j]));
            end
            read_check("ctrl", `MUL_ADDR_CTRL, {31'b0, t.mode});
        end
        write_word(`MUL_ADDR_START, 32'h1);
        // first read lands before the capture edge
        read_check("status_after_start", `MUL_ADDR_STATUS, 32'h0);
        wait_done();
        // snapshot must keep the z used by this start
        write_word(`MUL_ADDR_Z_BASE, ~sext(t.z[0]));
        for (int j = 0; j < `MUL_N; j++) begin
            read_check($sformatf("zsnap_%0d", j), 12'(`MUL_ADDR_ZSNAP_BASE + 4*j), sext(t.z[j]));
        end
        for (int k = 0; k < `MUL_N; k++) begin
            for (int i = 0; i < `MUL_N; i++) begin
                for (int j = 0; j < `MUL_N; j++) begin
                    read_check($sformatf("res_%0d_%0d_%0d_case%0d", k, i, j, c),
                               12'(`MUL_ADDR_RES_BASE + 4*(16*k + 4*i + j)),
                               expected(t, k, i, j));
                end
            end
        end
    endtask

    initial begin
        req    = '0;
        errors = 0;
        seed   = 32'hb84b_b553;
        build_table();
        wait (rst_n === 1'b1);
        read_check("status_after_reset", `MUL_ADDR_STATUS, 32'h0);
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        expect_error("pslverr_result_write", 1'b1, `MUL_ADDR_RES_BASE);
        expect_error("pslverr_status_write", 1'b1, `MUL_ADDR_STATUS);
        expect_error("pslverr_unmapped_read", 1'b0, 12'h070);
        // stored results survive the rejected accesses
        read_check("res_0_0_0_kept", `MUL_ADDR_RES_BASE,
                   expected(cases[NUM_CASES-1], 0, 0, 0));
        read_check("res_3_3_3_kept", 12'(`MUL_ADDR_RES_BASE + 4*63),
                   expected(cases[NUM_CASES-1], 3, 3, 3));
        bus_idle();
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (NUM_CASES * CASE_CYCLES) @(posedge clk_mul);
        errors++;
        $display("timeout, the test did not finish within %0d cycles", NUM_CASES * CASE_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: list.f
+incdir+logic
logic/fixed_pkg.sv
logic/apb_pkg.sv
logic/weight_regfile.sv
logic/outer_product_array.sv
logic/product_readout.sv
logic/outer_product_top.sv
verification/tb_clock_gen.sv
verification/outer_product_tb.sv

// File: run.sh
#!/bin/sh
# build and run the outer product testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f \
    --top-module outer_product_tb -o sim_outer_product

out=$(./obj_dir/sim_outer_product || true)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
